// File: src/exSettings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// register and memory data width
`define EX_DATA_W 64

// register id width, and the id used when nothing is written
`define EX_REG_ID_W 7
`define EX_REG_ZZR 7'h7F

// immediate width, bit 32 carries the sign
`define EX_IMM_W 33

// cycles from multiply issue until DLR/DHR are valid
`define EX_MUL_LATENCY 3
`define EX_TIMER_W 2

`endif

// File: src/exPkg.sv
package exPkg;

	// micro-ops handled by the integer execute stage
	typedef enum logic [7:0] {
		OP_NOP      = 8'h00,
		OP_MOV_RR   = 8'h01,
		OP_MOV_IR   = 8'h02,
		OP_ADD3     = 8'h03,
		OP_SUB3     = 8'h04,
		OP_ADC3     = 8'h05,
		OP_SBB3     = 8'h06,
		OP_AND3     = 8'h07,
		OP_OR3      = 8'h08,
		OP_XOR3     = 8'h09,
		OP_TST      = 8'h0A,
		OP_CMPEQ    = 8'h0B,
		OP_CMPHI    = 8'h0C,
		OP_CMPGT    = 8'h0D,
		OP_MULU     = 8'h0E,
		OP_MULS     = 8'h0F,
		OP_MOVB_RM  = 8'h10,
		OP_MOVW_RM  = 8'h11,
		OP_MOVL_RM  = 8'h12,
		OP_MOVQ_RM  = 8'h13,
		OP_MOVB_MR  = 8'h14,
		OP_MOVW_MR  = 8'h15,
		OP_MOVL_MR  = 8'h16,
		OP_MOVQ_MR  = 8'h17,
		OP_MOVUB_MR = 8'h18,
		OP_MOVUW_MR = 8'h19,
		OP_MOVUL_MR = 8'h1A
	} exOpcode;

	// memory op modes, READY means no request
	typedef enum logic [4:0] {
		MEM_READY = 5'h00,
		MEM_WR_SB = 5'h01,
		MEM_WR_SW = 5'h02,
		MEM_WR_SL = 5'h03,
		MEM_WR_Q  = 5'h04,
		MEM_RD_SB = 5'h05,
		MEM_RD_SW = 5'h06,
		MEM_RD_SL = 5'h07,
		MEM_RD_Q  = 5'h08,
		MEM_RD_UB = 5'h09,
		MEM_RD_UW = 5'h0A,
		MEM_RD_UL = 5'h0B
	} exMemMode;

	typedef enum logic [1:0] {
		STAT_OK   = 2'h0,
		STAT_HOLD = 2'h1
	} exStatus;

	typedef enum logic [1:0] {
		SEQ_IDLE    = 2'h0,
		SEQ_MULWAIT = 2'h1,
		SEQ_MEMWAIT = 2'h2,
		SEQ_MEMDONE = 2'h3
	} exSeqState;

endpackage

// File: src/exMemIf.sv
// one memory request between the sequencer and the memory stage
interface exMemIf;

	// mode of the standing request, READY when idle
	exPkg::exMemMode reqMode;

	// pulse in the cycle the memory answers OK
	logic done;

	// memory still answering HOLD
	logic busy;

	modport seq (
		output reqMode,
		output done,
		input  busy
	);

	modport mem (
		input  reqMode,
		input  done,
		output busy
	);

endinterface

// File: src/exAlu.sv
`include "exSettings.svh"

module exAlu import exPkg::*; (
	input  exOpcode                opCmd,
	input  logic [`EX_DATA_W-1:0] regValRm,
	input  logic [`EX_DATA_W-1:0] regValRn,
	input  logic [`EX_DATA_W-1:0] regValRi,
	input  logic [`EX_IMM_W-1:0]  immValRi,
	input  logic                  carryIn,
	output logic [`EX_DATA_W-1:0] aluVal,
	output logic                  aluWrite,
	output logic                  aluFlagWrite,
	output logic                  aluFlagT
);

	// 16-bit blocks with both carry-ins picked along the carry chain
	function automatic logic [`EX_DATA_W:0] csAdd(
		input logic [`EX_DATA_W-1:0] a,
		input logic [`EX_DATA_W-1:0] b,
		input logic                  cin
	);
		logic [16:0] sum0;
		logic [16:0] sum1;
		logic [`EX_DATA_W:0] res;
		logic carry;
		carry = cin;
		res = '0;
		for (int i = 0; i < `EX_DATA_W / 16; i++) begin
			sum0 = {1'b0, a[16*i +: 16]} + {1'b0, b[16*i +: 16]};
			sum1 = {1'b0, a[16*i +: 16]} + {1'b0, b[16*i +: 16]} + 17'd1;
			res[16*i +: 16] = carry ? sum1[15:0] : sum0[15:0];
			carry = carry ? sum1[16] : sum0[16];
		end
		res[`EX_DATA_W] = carry;
		return res;
	endfunction

	logic [`EX_DATA_W:0] addC0;
	logic [`EX_DATA_W:0] addC1;
	logic [`EX_DATA_W:0] subC0;
	logic [`EX_DATA_W:0] subC1;
	logic [`EX_DATA_W:0] adcRes;
	logic [`EX_DATA_W:0] sbbRes;
	logic [`EX_DATA_W-1:0] immExt;

	assign addC0 = csAdd(regValRm, regValRi, 1'b0);
	assign addC1 = csAdd(regValRm, regValRi, 1'b1);
	assign subC0 = csAdd(regValRm, ~regValRi, 1'b0);
	assign subC1 = csAdd(regValRm, ~regValRi, 1'b1);

	// T is the carry for ADC3 and the borrow for SBB3
	assign adcRes = carryIn ? addC1 : addC0;
	assign sbbRes = carryIn ? subC0 : subC1;

	assign immExt = {{(`EX_DATA_W - `EX_IMM_W + 1){immValRi[`EX_IMM_W-1]}},
		immValRi[`EX_IMM_W-2:0]};

	assign aluWrite = opCmd inside {OP_MOV_RR, OP_MOV_IR, OP_ADD3, OP_SUB3,
		OP_ADC3, OP_SBB3, OP_AND3, OP_OR3, OP_XOR3};
	assign aluFlagWrite = opCmd inside {OP_ADC3, OP_SBB3, OP_TST, OP_CMPEQ,
		OP_CMPHI, OP_CMPGT};

	always_comb begin
		aluVal = '0;
		aluFlagT = 1'b0;
		case (opCmd)
			OP_MOV_RR: aluVal = regValRm;
			OP_MOV_IR: aluVal = immExt;
			OP_ADD3:   aluVal = addC0[`EX_DATA_W-1:0];
			OP_SUB3:   aluVal = subC1[`EX_DATA_W-1:0];
			OP_ADC3: begin
				aluVal = adcRes[`EX_DATA_W-1:0];
				aluFlagT = adcRes[`EX_DATA_W];
			end
			OP_SBB3: begin
				aluVal = sbbRes[`EX_DATA_W-1:0];
				aluFlagT = !sbbRes[`EX_DATA_W];
			end
			OP_AND3:  aluVal = regValRm & regValRi;
			OP_OR3:   aluVal = regValRm | regValRi;
			OP_XOR3:  aluVal = regValRm ^ regValRi;
			// flag ops look at the low 32 bits only
			OP_TST:   aluFlagT = (regValRn[31:0] & regValRm[31:0]) == 32'h0;
			OP_CMPEQ: aluFlagT = regValRn[31:0] == regValRm[31:0];
			OP_CMPHI: aluFlagT = regValRn[31:0] > regValRm[31:0];
			OP_CMPGT: aluFlagT = $signed(regValRn[31:0]) > $signed(regValRm[31:0]);
			default:  aluVal = '0;
		endcase
	end

	// carry-select chain must agree with a plain 65-bit add
	always_comb begin
		assert (addC0 == {1'b0, regValRm} + {1'b0, regValRi});
		assert (addC1 == {1'b0, regValRm} + {1'b0, regValRi} + 65'd1);
	end

endmodule

// File: src/exMulPipe.sv
module exMulPipe (
	input  logic        clock,
	input  logic        rstN,
	input  logic [31:0] mulA,
	input  logic [31:0] mulB,
	input  logic        mulSigned,
	output logic [31:0] mulLo,
	output logic [31:0] mulHi
);

	logic [31:0] regA;
	logic [31:0] regB;
	logic        regSigned;
	logic [31:0] fixA;
	logic [31:0] fixB;
	logic [31:0] ppLL;
	logic [31:0] ppLH;
	logic [31:0] ppHL;
	logic [31:0] ppHH;
	logic [31:0] ppFix;
	logic [63:0] product;

	// stage 1, operand capture
	always_ff @(posedge clock) begin
		regA <= mulA;
		regB <= mulB;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			regSigned <= 1'b0;
		end else begin
			regSigned <= mulSigned;
		end
	end

	// signed correction, subtract the other operand in the upper word
	assign fixA = regA[31] ? -regB : 32'h0;
	assign fixB = regB[31] ? -regA : 32'h0;

	// stage 2, 16x16 partial products
	always_ff @(posedge clock) begin
		ppLL <= 32'(regA[15:0]) * 32'(regB[15:0]);
		ppLH <= 32'(regA[15:0]) * 32'(regB[31:16]);
		ppHL <= 32'(regA[31:16]) * 32'(regB[15:0]);
		ppHH <= 32'(regA[31:16]) * 32'(regB[31:16]);
		ppFix <= regSigned ? fixA + fixB : 32'h0;
	end

	// stage 3, final sum
	always_ff @(posedge clock) begin
		product <= {32'h0, ppLL} + {16'h0, ppLH, 16'h0} + {16'h0, ppHL, 16'h0} +
			{ppHH, 32'h0} + {ppFix, 32'h0};
	end

	assign mulLo = product[31:0];
	assign mulHi = product[63:32];

endmodule

// File: src/exMemStage.sv
`include "exSettings.svh"

module exMemStage import exPkg::*; (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [`EX_DATA_W-1:0] regValRm,
	input  logic [`EX_DATA_W-1:0] regValRi,
	input  logic [1:0]            ixScale,
	input  logic [`EX_DATA_W-1:0] regValRn,
	exMemIf.mem                   memPort,
	input  logic [`EX_DATA_W-1:0] memDataLd,
	input  exStatus               memDataOK,
	output logic [`EX_DATA_W-1:0] memAddr,
	output logic [`EX_DATA_W-1:0] memData,
	output exMemMode              memOpm,
	output logic [`EX_DATA_W-1:0] loadVal
);

	logic [`EX_DATA_W-1:0] ldRaw;
	exMemMode ldMode;

	// scaled-index address, base Rm
	assign memAddr = regValRm + (regValRi << ixScale);
	assign memData = regValRn;
	assign memOpm = memPort.reqMode;
	assign memPort.busy = memDataOK != STAT_OK;

	always_ff @(posedge clock) begin
		if (memPort.done) begin
			ldRaw <= memDataLd;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			ldMode <= MEM_READY;
		end else if (memPort.done) begin
			ldMode <= memPort.reqMode;
		end
	end

	// narrow the raw word to the load size
	always_comb begin
		case (ldMode)
			MEM_RD_SB: loadVal = {{(`EX_DATA_W-8){ldRaw[7]}}, ldRaw[7:0]};
			MEM_RD_SW: loadVal = {{(`EX_DATA_W-16){ldRaw[15]}}, ldRaw[15:0]};
			MEM_RD_SL: loadVal = {{(`EX_DATA_W-32){ldRaw[31]}}, ldRaw[31:0]};
			MEM_RD_UB: loadVal = {{(`EX_DATA_W-8){1'b0}}, ldRaw[7:0]};
			MEM_RD_UW: loadVal = {{(`EX_DATA_W-16){1'b0}}, ldRaw[15:0]};
			MEM_RD_UL: loadVal = {{(`EX_DATA_W-32){1'b0}}, ldRaw[31:0]};
			default:   loadVal = ldRaw;
		endcase
	end

	// request is dropped right after the memory answers
	assert property (@(posedge clock) disable iff (!rstN)
		memPort.done |=> memOpm == MEM_READY);

endmodule

// File: src/exHoldTimer.sv
`include "exSettings.svh"

module exHoldTimer (
	input  logic clock,
	input  logic rstN,
	input  logic enable,
	output logic expired
);

	localparam logic [`EX_TIMER_W-1:0] LAST_COUNT = `EX_TIMER_W'(`EX_MUL_LATENCY - 1);

	logic [`EX_TIMER_W-1:0] count;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			count <= '0;
		end else if (enable) begin
			count <= count + 1'b1;
		end else begin
			count <= '0;
		end
	end

	assign expired = count == LAST_COUNT;

	// sequencer drops enable once the terminal count shows
	assert property (@(posedge clock) disable iff (!rstN) count <= LAST_COUNT);

endmodule

// File: src/exSequencer.sv
`include "exSettings.svh"

module exSequencer import exPkg::*; (
	input  logic                    clock,
	input  logic                    rstN,
	input  exOpcode                 opCmd,
	input  logic [`EX_REG_ID_W-1:0] regIdRn,
	input  logic [`EX_DATA_W-1:0]   aluVal,
	input  logic                    aluWrite,
	input  logic                    aluFlagWrite,
	input  logic                    aluFlagT,
	input  logic [31:0]             mulLo,
	input  logic [31:0]             mulHi,
	input  logic                    expired,
	input  logic [`EX_DATA_W-1:0]   loadVal,
	input  logic [`EX_DATA_W-1:0]   ctlInSr,
	input  logic [`EX_DATA_W-1:0]   ctlInDlr,
	input  logic [`EX_DATA_W-1:0]   ctlInDhr,
	exMemIf.seq                     memPort,
	output logic                    timerEnable,
	output logic                    mulSigned,
	output logic [`EX_REG_ID_W-1:0] regOutId,
	output logic [`EX_DATA_W-1:0]   regOutVal,
	output exStatus                 regOutOK,
	output logic [`EX_DATA_W-1:0]   ctlOutSr,
	output logic [`EX_DATA_W-1:0]   ctlOutDlr,
	output logic [`EX_DATA_W-1:0]   ctlOutDhr
);

	exSeqState state;
	exSeqState nextState;
	exMemMode opMode;
	logic isMul;
	logic isMem;
	logic isLoad;

	// opcode groups
	always_comb begin
		case (opCmd)
			OP_MOVB_RM:  opMode = MEM_WR_SB;
			OP_MOVW_RM:  opMode = MEM_WR_SW;
			OP_MOVL_RM:  opMode = MEM_WR_SL;
			OP_MOVQ_RM:  opMode = MEM_WR_Q;
			OP_MOVB_MR:  opMode = MEM_RD_SB;
			OP_MOVW_MR:  opMode = MEM_RD_SW;
			OP_MOVL_MR:  opMode = MEM_RD_SL;
			OP_MOVQ_MR:  opMode = MEM_RD_Q;
			OP_MOVUB_MR: opMode = MEM_RD_UB;
			OP_MOVUW_MR: opMode = MEM_RD_UW;
			OP_MOVUL_MR: opMode = MEM_RD_UL;
			default:     opMode = MEM_READY;
		endcase
	end

	assign isMem = opMode != MEM_READY;
	assign isLoad = opMode inside {MEM_RD_SB, MEM_RD_SW, MEM_RD_SL, MEM_RD_Q,
		MEM_RD_UB, MEM_RD_UW, MEM_RD_UL};
	assign isMul = opCmd inside {OP_MULU, OP_MULS};
	assign mulSigned = opCmd == OP_MULS;

	// request stands from issue until the memory answers OK
	assign memPort.reqMode = (state == SEQ_IDLE || state == SEQ_MEMWAIT) ? opMode : MEM_READY;
	assign memPort.done = (memPort.reqMode != MEM_READY) && !memPort.busy;

	assign timerEnable = (state == SEQ_MULWAIT) && !expired;

	always_comb begin
		nextState = state;
		case (state)
			SEQ_IDLE: begin
				if (isMul) begin
					nextState = SEQ_MULWAIT;
				end else if (isMem) begin
					nextState = memPort.done ? SEQ_MEMDONE : SEQ_MEMWAIT;
				end
			end
			SEQ_MULWAIT: nextState = expired ? SEQ_IDLE : SEQ_MULWAIT;
			SEQ_MEMWAIT: nextState = memPort.done ? SEQ_MEMDONE : SEQ_MEMWAIT;
			default:     nextState = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= SEQ_IDLE;
		end else begin
			state <= nextState;
		end
	end

	// status and write-back select
	always_comb begin
		regOutOK = STAT_OK;
		regOutId = `EX_REG_ZZR;
		regOutVal = '0;
		ctlOutSr = ctlInSr;
		ctlOutDlr = ctlInDlr;
		ctlOutDhr = ctlInDhr;
		case (state)
			SEQ_IDLE: begin
				if (isMul || isMem) begin
					regOutOK = STAT_HOLD;
				end else begin
					if (aluWrite) begin
						regOutId = regIdRn;
						regOutVal = aluVal;
					end
					if (aluFlagWrite) begin
						ctlOutSr[0] = aluFlagT;
					end
				end
			end
			SEQ_MULWAIT: begin
				if (!expired) begin
					regOutOK = STAT_HOLD;
				end else if (mulSigned) begin
					ctlOutDlr = {{(`EX_DATA_W-32){mulLo[31]}}, mulLo};
					ctlOutDhr = {{(`EX_DATA_W-32){mulHi[31]}}, mulHi};
				end else begin
					ctlOutDlr = {{(`EX_DATA_W-32){1'b0}}, mulLo};
					ctlOutDhr = {{(`EX_DATA_W-32){1'b0}}, mulHi};
				end
			end
			SEQ_MEMWAIT: regOutOK = STAT_HOLD;
			default: begin
				if (isLoad) begin
					regOutId = regIdRn;
					regOutVal = loadVal;
				end
			end
		endcase
	end

	// multiply result falls due exactly the latency after issue
	assert property (@(posedge clock) disable iff (!rstN)
		expired |-> $past(state, `EX_MUL_LATENCY) == SEQ_IDLE &&
			$past(state, `EX_MUL_LATENCY - 1) == SEQ_MULWAIT);

endmodule

// File: src/execUnit.sv
`include "exSettings.svh"

module execUnit import exPkg::*; (
	input  logic                    clock,
	input  logic                    rstN,
	input  exOpcode                 opCmd,
	input  logic [`EX_REG_ID_W-1:0] regIdRn,
	input  logic [`EX_DATA_W-1:0]   regValRm,
	input  logic [`EX_DATA_W-1:0]   regValRn,
	input  logic [`EX_DATA_W-1:0]   regValRi,
	input  logic [`EX_IMM_W-1:0]    immValRi,
	input  logic [1:0]              ixScale,
	input  logic [`EX_DATA_W-1:0]   ctlInSr,
	input  logic [`EX_DATA_W-1:0]   ctlInDlr,
	input  logic [`EX_DATA_W-1:0]   ctlInDhr,
	output logic [`EX_REG_ID_W-1:0] regOutId,
	output logic [`EX_DATA_W-1:0]   regOutVal,
	output exStatus                 regOutOK,
	output logic [`EX_DATA_W-1:0]   ctlOutSr,
	output logic [`EX_DATA_W-1:0]   ctlOutDlr,
	output logic [`EX_DATA_W-1:0]   ctlOutDhr,
	output logic [`EX_DATA_W-1:0]   memAddr,
	output logic [`EX_DATA_W-1:0]   memData,
	output exMemMode                memOpm,
	input  logic [`EX_DATA_W-1:0]   memDataLd,
	input  exStatus                 memDataOK
);

	logic [`EX_DATA_W-1:0] aluVal;
	logic                  aluWrite;
	logic                  aluFlagWrite;
	logic                  aluFlagT;
	logic [31:0]           mulLo;
	logic [31:0]           mulHi;
	logic                  mulSigned;
	logic                  timerEnable;
	logic                  expired;
	logic [`EX_DATA_W-1:0] loadVal;

	exMemIf memBus ();

	exAlu exAlu_inst (
		.opCmd(opCmd), .regValRm(regValRm), .regValRn(regValRn),
		.regValRi(regValRi), .immValRi(immValRi), .carryIn(ctlInSr[0]),
		.aluVal(aluVal), .aluWrite(aluWrite), .aluFlagWrite(aluFlagWrite),
		.aluFlagT(aluFlagT)
	);

	// multiplies Rn by Rm, low words only
	exMulPipe exMulPipe_inst (
		.clock(clock), .rstN(rstN), .mulA(regValRn[31:0]), .mulB(regValRm[31:0]),
		.mulSigned(mulSigned), .mulLo(mulLo), .mulHi(mulHi)
	);

	exMemStage exMemStage_inst (
		.clock(clock), .rstN(rstN), .regValRm(regValRm), .regValRi(regValRi),
		.ixScale(ixScale), .regValRn(regValRn), .memPort(memBus.mem),
		.memDataLd(memDataLd), .memDataOK(memDataOK), .memAddr(memAddr),
		.memData(memData), .memOpm(memOpm), .loadVal(loadVal)
	);

	exHoldTimer exHoldTimer_inst (
		.clock(clock), .rstN(rstN), .enable(timerEnable), .expired(expired)
	);

	exSequencer exSequencer_inst (
		.clock(clock), .rstN(rstN), .opCmd(opCmd), .regIdRn(regIdRn),
		.aluVal(aluVal), .aluWrite(aluWrite), .aluFlagWrite(aluFlagWrite),
		.aluFlagT(aluFlagT), .mulLo(mulLo), .mulHi(mulHi), .expired(expired),
		.loadVal(loadVal), .ctlInSr(ctlInSr), .ctlInDlr(ctlInDlr),
		.ctlInDhr(ctlInDhr), .memPort(memBus.seq), .timerEnable(timerEnable),
		.mulSigned(mulSigned), .regOutId(regOutId), .regOutVal(regOutVal),
		.regOutOK(regOutOK), .ctlOutSr(ctlOutSr), .ctlOutDlr(ctlOutDlr),
		.ctlOutDhr(ctlOutDhr)
	);

endmodule

// File: verification/tbClockGen.sv
// free-running testbench clock, period 4
module tbClockGen (
	output logic clock
);

	initial begin
		clock = 1'b0;
	end

	always begin
		#2 clock = ~clock;
	end

endmodule

// File: verification/execUnitTb.sv
`include "exSettings.svh"

module execUnitTb import exPkg::*; ();

	logic clock, rstN;
	exOpcode opCmd;
	logic [`EX_REG_ID_W-1:0] regIdRn, regOutId;
	logic [63:0] regValRm, regValRn, regValRi, ctlInSr, ctlInDlr, ctlInDhr;
	logic [`EX_IMM_W-1:0] immValRi;
	logic [1:0] ixScale;
	logic [63:0] regOutVal, ctlOutSr, ctlOutDlr, ctlOutDhr, memAddr, memData, memDataLd;
	exStatus regOutOK, memDataOK;
	exMemMode memOpm;

	// one entry per vector line
	logic [7:0] vOp [0:63];
	logic [6:0] vId [0:63], vExpId [0:63];
	logic [63:0] vRm [0:63], vRn [0:63], vRi [0:63], vSr [0:63], vLd [0:63];
	logic [32:0] vImm [0:63];
	logic [1:0] vScale [0:63];
	logic [63:0] vExpVal [0:63], vExpDlr [0:63], vExpDhr [0:63];
	logic vExpT [0:63];
	int vWait [0:63];
	int numVec = 0;
	int testErrors = 0;
	int failedTests = 0;
	int totalErrors = 0;
	bit loaded = 0;

	tbClockGen clockGen_inst (.clock(clock));

	execUnit execUnit_inst (
		.clock(clock), .rstN(rstN), .opCmd(opCmd), .regIdRn(regIdRn),
		.regValRm(regValRm), .regValRn(regValRn), .regValRi(regValRi),
		.immValRi(immValRi), .ixScale(ixScale), .ctlInSr(ctlInSr),
		.ctlInDlr(ctlInDlr), .ctlInDhr(ctlInDhr), .regOutId(regOutId),
		.regOutVal(regOutVal), .regOutOK(regOutOK), .ctlOutSr(ctlOutSr),
		.ctlOutDlr(ctlOutDlr), .ctlOutDhr(ctlOutDhr), .memAddr(memAddr),
		.memData(memData), .memOpm(memOpm), .memDataLd(memDataLd),
		.memDataOK(memDataOK)
	);

	// mode that each memory opcode must put on memOpm
	function automatic exMemMode modeFor(input logic [7:0] op);
		case (op)
			8'h10: return MEM_WR_SB;
			8'h11: return MEM_WR_SW;
			8'h12: return MEM_WR_SL;
			8'h13: return MEM_WR_Q;
			8'h14: return MEM_RD_SB;
			8'h15: return MEM_RD_SW;
			8'h16: return MEM_RD_SL;
			8'h17: return MEM_RD_Q;
			8'h18: return MEM_RD_UB;
			8'h19: return MEM_RD_UW;
			8'h1A: return MEM_RD_UL;
			default: return MEM_READY;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic readVectors();
		int fd, n;
		string line;
		int op, id, scale, waitCyc, expId, expT;
		logic [63:0] rm, rn, ri, imm, sr, ld, expVal, expDlr, expDhr;
		fd = $fopen("verification/execVectors.txt", "r");
		if (fd == 0) begin
			return;
		end
		while (!$feof(fd) && numVec < 64) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != 8'h23) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					op, id, rm, rn, ri, imm, scale, sr, ld, waitCyc,
					expVal, expId, expT, expDlr, expDhr);
				if (n == 15) begin
					vOp[numVec] = 8'(op);
					vId[numVec] = 7'(id);
					vRm[numVec] = rm;
					vRn[numVec] = rn;
					vRi[numVec] = ri;
					vImm[numVec] = 33'(imm);
					vScale[numVec] = 2'(scale);
					vSr[numVec] = sr;
					vLd[numVec] = ld;
					vWait[numVec] = waitCyc;
					vExpVal[numVec] = expVal;
					vExpId[numVec] = 7'(expId);
					vExpT[numVec] = expT[0];
					vExpDlr[numVec] = expDlr;
					vExpDhr[numVec] = expDhr;
					numVec++;
				end
			end
		end
		$fclose(fd);
	endtask

	// watchdog scaled by the number of vectors plus the reset time
	initial begin
		wait (loaded);
		#(numVec * (4 + `EX_MUL_LATENCY + 4) * 4 * 2 + 20 * 4);
		$display("watchdog expired before all vectors finished");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int waitCycles, holdLeft, holdCount, expHold;
		bit isMem, isMul, finished;
		logic [63:0] expAddr;
		void'($urandom(32'hb208_4f5c));
		rstN = 1'b0;
		opCmd = OP_NOP;
		regIdRn = '0;
		regValRm = '0;
		regValRn = '0;
		regValRi = '0;
		immValRi = '0;
		ixScale = '0;
		ctlInSr = '0;
		ctlInDlr = '0;
		ctlInDhr = '0;
		memDataLd = '0;
		memDataOK = STAT_HOLD;
		readVectors();
		loaded = 1;
		if (numVec == 0) begin
			$display("vector file missing or holding no vectors");
			failedTests++;
		end
		repeat (10) @(posedge clock);
		rstN <= 1'b1;

		// reset state with a NOP
		@(negedge clock);
		testErrors = 0;
		compareValue("memOpm", 64'(memOpm), 64'(MEM_READY));
		compareValue("regOutOK", 64'(regOutOK), 64'(STAT_OK));
		$display("test reset: %s", testErrors == 0 ? "ok" : "failed");
		if (testErrors != 0) failedTests++;
		totalErrors += testErrors;

		for (int v = 0; v < numVec; v++) begin
			testErrors = 0;
			isMem = modeFor(vOp[v]) != MEM_READY;
			isMul = vOp[v] == 8'h0E || vOp[v] == 8'h0F;
			waitCycles = vWait[v];
			if (isMem && waitCycles == 0) begin
				waitCycles = int'($urandom % 4) + 1;
			end
			holdLeft = waitCycles;
			expAddr = vRm[v] + vRi[v] * (64'd1 << vScale[v]);
			@(posedge clock);
			opCmd <= exOpcode'(vOp[v]);
			regIdRn <= vId[v];
			regValRm <= vRm[v];
			regValRn <= vRn[v];
			regValRi <= vRi[v];
			immValRi <= vImm[v];
			ixScale <= vScale[v];
			ctlInSr <= vSr[v];
			memDataLd <= vLd[v];
			memDataOK <= holdLeft > 0 ? STAT_HOLD : STAT_OK;
			holdCount = 0;
			finished = 0;
			while (!finished) begin
				@(negedge clock);
				if (regOutOK == STAT_OK) begin
					finished = 1;
				end else begin
					holdCount++;
					// request must stand unchanged while waiting
					if (isMem) begin
						compareValue("memOpm", 64'(memOpm), 64'(modeFor(vOp[v])));
						compareValue("memAddr", memAddr, expAddr);
						compareValue("memData", memData, vRn[v]);
					end
					@(posedge clock);
					if (holdLeft > 0) holdLeft--;
					memDataOK <= holdLeft > 0 ? STAT_HOLD : STAT_OK;
				end
			end
			expHold = isMul ? `EX_MUL_LATENCY : (isMem ? waitCycles + 1 : 0);
			if (holdCount != expHold) begin
				$display("hold lasted %0d cycles where %0d were expected", holdCount, expHold);
				testErrors++;
			end
			compareValue("regOutVal", regOutVal, vExpVal[v]);
			compareValue("regOutId", 64'(regOutId), 64'(vExpId[v]));
			compareValue("ctlOutSr", ctlOutSr, {vSr[v][63:1], vExpT[v]});
			compareValue("ctlOutDlr", ctlOutDlr, vExpDlr[v]);
			compareValue("ctlOutDhr", ctlOutDhr, vExpDhr[v]);
			compareValue("memOpm", 64'(memOpm), 64'(MEM_READY));
			$display("test %0d opcode %h: %s", v, vOp[v], testErrors == 0 ? "ok" : "failed");
			if (testErrors != 0) failedTests++;
			totalErrors += testErrors;
		end

		$display("tests run %0d, tests failed %0d, errors %0d", numVec + 1, failedTests,
			totalErrors);
		if (failedTests == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verification/execVectors.txt
# op id rm rn ri imm scale sr ldWord wait (0 = random) | expected: val id srT dlr dhr
# all fields hex
03 05 FFFFFFFFFFFFFFFF 0 2 0 0 0 0 0 1 05 0 0 0
04 06 10 0 3 0 0 1 0 0 D 06 1 0 0
05 07 FFFFFFFFFFFFFFFF 0 0 0 0 1 0 0 0 07 1 0 0
05 08 123 0 456 0 0 0 0 0 579 08 0 0 0
06 09 5 0 3 0 0 1 0 0 1 09 0 0 0
06 0A 0 0 1 0 0 0 0 0 FFFFFFFFFFFFFFFF 0A 1 0 0
07 0B F0F0 0 FF00 0 0 0 0 0 F000 0B 0 0 0
08 0C F0F0 0 0F0F 0 0 0 0 0 FFFF 0C 0 0 0
09 0D FF 0 0F 0 0 0 0 0 F0 0D 0 0 0
01 0E DEADBEEF12345678 0 0 0 0 0 0 0 DEADBEEF12345678 0E 0 0 0
02 0F 0 0 0 1FFFFFFF0 0 0 0 0 FFFFFFFFFFFFFFF0 0F 0 0 0
02 10 0 0 0 07FFFFFFF 0 0 0 0 7FFFFFFF 10 0 0 0
0A 11 0F F0 0 0 0 0 0 0 0 7F 1 0 0
0B 11 5 FFFFFFFF00000005 0 0 0 0 0 0 0 7F 1 0 0
0C 11 FFFFFFFF 1 0 0 0 1 0 0 0 7F 0 0 0
0D 11 FFFFFFFF 1 0 0 0 0 0 0 0 7F 1 0 0
0E 11 2 FFFFFFFF 0 0 0 0 0 0 0 7F 0 FFFFFFFE 1
0F 11 2 FFFFFFFF 0 0 0 0 0 0 0 7F 0 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF
12 11 1000 CAFEF00D 4 0 2 0 0 2 0 7F 0 0 0
13 11 2000 0123456789ABCDEF 3 0 3 0 0 0 0 7F 0 0 0
14 11 3000 0 1 0 0 0 F0 3 FFFFFFFFFFFFFFF0 11 0 0 0
19 12 3000 0 2 0 1 0 123456789ABCDEF0 0 DEF0 12 0 0 0
16 13 4000 0 8 0 0 0 80000001 1 FFFFFFFF80000001 13 0 0 0
1A 14 4000 0 8 0 3 0 80000001 0 80000001 14 0 0 0

// File: files.f
+incdir+src
src/exPkg.sv
src/exMemIf.sv
src/exAlu.sv
src/exMulPipe.sv
src/exMemStage.sv
src/exHoldTimer.sv
src/exSequencer.sv
src/execUnit.sv
verification/tbClockGen.sv
verification/execUnitTb.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module execUnitTb \
	-Mdir build -o simExec
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./build/simExec > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
